//--- rtl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // word memory geometry
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS); // word index is addr[MEM_IDX_W+1:2]

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } access_size_t;

    typedef enum logic [1:0] {
        FE_LOAD_ACCESS  = 2'd0,
        FE_STORE_ACCESS = 2'd1
    } fault_t;

    // requester side at any byte address
    typedef struct packed {
        logic         valid;
        logic         wen;
        access_size_t size;
        logic [31:0]  addr;
        logic [31:0]  wdata;
    } data_req_t;

    typedef struct packed {
        logic        valid; // one-cycle pulse
        logic        error;
        fault_t      errty;
        logic [31:0] rdata;
    } data_resp_t;

    // memory side with word aligned addresses only
    typedef struct packed {
        logic        valid;
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic        error;
        fault_t      errty;
        logic [31:0] rdata;
    } mem_resp_t;

endpackage

`default_nettype wire

//--- rtl/guard_pkg.sv
`default_nettype none

package guard_pkg;

    // offsets on the 2-bit config address
    localparam logic [1:0] GUARD_REG_BASE  = 2'd0;
    localparam logic [1:0] GUARD_REG_LIMIT = 2'd1;
    localparam logic [1:0] GUARD_REG_MODE  = 2'd2;

    typedef struct packed {
        logic [7:0] base;        // first protected word index
        logic [7:0] limit;       // last protected word index included
        logic       enable;
        logic       block_reads; // loads fault too
    } guard_cfg_t;

    localparam guard_cfg_t GUARD_CFG_RESET = '{
        base:        8'd0,
        limit:       8'd0,
        enable:      1'b0,
        block_reads: 1'b0
    };

endpackage

`default_nettype wire

//--- rtl/misaligned_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module misaligned_access_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_bus_pkg::data_req_t  dreq,
    output logic                   dreq_ready,
    output mem_bus_pkg::data_resp_t dresp,
    output mem_bus_pkg::mem_req_t   memreq,
    input  logic                   memreq_ready,
    input  mem_bus_pkg::mem_resp_t  memresp
);

    typedef enum logic [3:0] {
        IDLE,
        LD1_REQ,
        LD1_WAIT,
        LD2_REQ,
        LD2_WAIT,
        MERGE,
        ST1_REQ,
        ST1_WAIT,
        ST2_REQ,
        ST2_WAIT,
        RESP
    } state_t;

    state_t                  state;
    mem_bus_pkg::data_req_t  req_q;     // latched request
    logic [31:0]             rdata1_q;
    logic [31:0]             rdata2_q;
    logic [31:0]             wdata1_q;
    logic [31:0]             wdata2_q;
    logic [31:0]             load_q;
    logic                    error_q;
    mem_bus_pkg::fault_t     errty_q;   // last fault seen

    logic [1:0]  byte_off;
    logic [31:0] word_addr;
    logic        split;
    logic [4:0]  shift;
    logic [7:0]  size_mask;
    logic [7:0]  lane_mask;
    logic [63:0] bit_mask;
    logic [63:0] read_window;
    logic [63:0] wdata_shifted;
    logic [63:0] merged;
    logic [31:0] load_word;
    logic        direct_store;

    assign byte_off  = req_q.addr[1:0];
    assign word_addr = {req_q.addr[31:2], 2'b00};

    // word at offset 1..3 or half at offset 3 crosses a word boundary
    assign split = (req_q.size == mem_bus_pkg::SIZE_W && byte_off != 2'd0) ||
                   (req_q.size == mem_bus_pkg::SIZE_H && byte_off == 2'd3);

    // aligned word store needs no read
    assign direct_store = dreq.wen && dreq.size == mem_bus_pkg::SIZE_W &&
                          dreq.addr[1:0] == 2'b00;

    assign shift         = {byte_off, 3'b000};
    assign read_window   = {rdata2_q, rdata1_q}; // little-endian pair
    assign wdata_shifted = {32'h0, req_q.wdata} << shift;
    assign load_word     = 32'(read_window >> shift);

    always_comb begin
        case (req_q.size)
            mem_bus_pkg::SIZE_H: size_mask = 8'h03;
            mem_bus_pkg::SIZE_W: size_mask = 8'h0f;
            default:             size_mask = 8'h01;
        endcase
        lane_mask = size_mask << byte_off;
        for (int i = 0; i < 8; i++) begin
            bit_mask[i*8 +: 8] = {8{lane_mask[i]}};
        end
    end

    assign merged = (read_window & ~bit_mask) | (wdata_shifted & bit_mask);

    assign dreq_ready = (state == IDLE);

    assign memreq.valid = (state == LD1_REQ) || (state == LD2_REQ) ||
                          (state == ST1_REQ) || (state == ST2_REQ);
    assign memreq.wen   = (state == ST1_REQ) || (state == ST2_REQ);
    assign memreq.addr  = (state == LD2_REQ || state == ST2_REQ) ? word_addr + 32'd4
                                                                 : word_addr;
    assign memreq.wdata = (state == ST2_REQ) ? wdata2_q : wdata1_q;

    assign dresp.valid = (state == RESP);
    assign dresp.error = error_q;
    assign dresp.errty = errty_q;
    assign dresp.rdata = load_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            error_q <= 1'b0;
            errty_q <= mem_bus_pkg::FE_LOAD_ACCESS;
        end else begin
            case (state)
                IDLE: begin
                    if (dreq.valid) begin
                        error_q <= 1'b0;
                        state   <= direct_store ? ST1_REQ : LD1_REQ;
                    end
                end
                LD1_REQ: begin
                    if (memreq_ready) state <= LD1_WAIT;
                end
                LD1_WAIT: begin
                    if (memresp.valid) begin
                        if (memresp.error) begin
                            error_q <= 1'b1;
                            errty_q <= memresp.errty;
                            state   <= RESP;
                        end else begin
                            state <= split ? LD2_REQ : MERGE;
                        end
                    end
                end
                LD2_REQ: begin
                    if (memreq_ready) state <= LD2_WAIT;
                end
                LD2_WAIT: begin
                    if (memresp.valid) begin
                        if (memresp.error) begin
                            error_q <= 1'b1;
                            errty_q <= memresp.errty;
                            state   <= RESP;
                        end else begin
                            state <= MERGE;
                        end
                    end
                end
                MERGE: begin
                    state <= req_q.wen ? ST1_REQ : RESP;
                end
                ST1_REQ: begin
                    if (memreq_ready) state <= ST1_WAIT;
                end
                ST1_WAIT: begin
                    if (memresp.valid) begin
                        if (memresp.error) begin
                            error_q <= 1'b1;
                            errty_q <= memresp.errty;
                            state   <= RESP;
                        end else begin
                            state <= split ? ST2_REQ : RESP;
                        end
                    end
                end
                ST2_REQ: begin
                    if (memreq_ready) state <= ST2_WAIT;
                end
                ST2_WAIT: begin
                    if (memresp.valid) begin
                        if (memresp.error) begin
                            error_q <= 1'b1;
                            errty_q <= memresp.errty;
                        end
                        state <= RESP; // first word stays written on a fault
                    end
                end
                RESP:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == IDLE && dreq.valid) begin
            req_q    <= dreq;
            wdata1_q <= dreq.wdata; // used as is by the direct store
        end
        if (state == LD1_WAIT && memresp.valid) rdata1_q <= memresp.rdata;
        if (state == LD2_WAIT && memresp.valid) rdata2_q <= memresp.rdata;
        if (state == MERGE) begin
            load_q   <= load_word;
            wdata1_q <= merged[31:0];
            wdata2_q <= merged[63:32];
        end
    end

    a_no_memreq_when_idle: assert property (@(posedge clk) disable iff (reset)
        dreq_ready && !dreq.valid |=> !memreq.valid);

    a_dresp_pulse: assert property (@(posedge clk) disable iff (reset)
        dresp.valid |=> !dresp.valid && dreq_ready);

endmodule

`default_nettype wire

//--- rtl/word_mem.sv
`timescale 1ns/1ps
`default_nettype none

module word_mem (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_bus_pkg::mem_req_t  memreq,
    output logic                   memreq_ready,
    output mem_bus_pkg::mem_resp_t memresp,
    input  guard_pkg::guard_cfg_t  guard_cfg
);

    logic [31:0] mem [mem_bus_pkg::MEM_WORDS];

    logic                          pending;   // response due this cycle
    logic                          error_q;
    mem_bus_pkg::fault_t           errty_q;
    logic [31:0]                   rdata_q;
    logic [mem_bus_pkg::MEM_IDX_W-1:0] idx;
    logic                          accept;
    logic                          in_window;
    logic                          fault;

    assign idx    = memreq.addr[mem_bus_pkg::MEM_IDX_W+1:2]; // upper bits wrap
    assign accept = memreq.valid && memreq_ready;

    assign in_window = idx >= guard_cfg.base && idx <= guard_cfg.limit;
    assign fault     = guard_cfg.enable && in_window &&
                       (memreq.wen || guard_cfg.block_reads);

    assign memreq_ready = !pending;

    assign memresp.valid = pending;
    assign memresp.error = error_q;
    assign memresp.errty = errty_q;
    assign memresp.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            pending <= accept; // ready is low while pending, so one cycle only
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            error_q <= fault;
            errty_q <= memreq.wen ? mem_bus_pkg::FE_STORE_ACCESS
                                  : mem_bus_pkg::FE_LOAD_ACCESS;
            rdata_q <= mem[idx]; // old contents on a write
            if (memreq.wen && !fault) begin
                mem[idx] <= memreq.wdata;
            end
        end
    end

    a_fault_keeps_word: assert property (@(posedge clk) disable iff (reset)
        accept && memreq.wen && fault |=> mem[$past(idx)] == $past(mem[idx]));

endmodule

`default_nettype wire

//--- rtl/guard_regs.sv
`timescale 1ns/1ps
`default_nettype none

module guard_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_wen,
    input  logic [1:0]            cfg_addr,
    input  logic [31:0]           cfg_wdata,
    output logic [31:0]           cfg_rdata,
    output guard_pkg::guard_cfg_t guard_cfg
);

    guard_pkg::guard_cfg_t cfg_q;

    assign guard_cfg = cfg_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= guard_pkg::GUARD_CFG_RESET;
        end else if (cfg_wen) begin
            case (cfg_addr)
                guard_pkg::GUARD_REG_BASE:  cfg_q.base  <= cfg_wdata[7:0];
                guard_pkg::GUARD_REG_LIMIT: cfg_q.limit <= cfg_wdata[7:0];
                guard_pkg::GUARD_REG_MODE: begin
                    cfg_q.enable      <= cfg_wdata[0];
                    cfg_q.block_reads <= cfg_wdata[1];
                end
                default: ; // offset 3 has no register
            endcase
        end
    end

    // unused bits read as zero
    always_comb begin
        case (cfg_addr)
            guard_pkg::GUARD_REG_BASE:  cfg_rdata = {24'h0, cfg_q.base};
            guard_pkg::GUARD_REG_LIMIT: cfg_rdata = {24'h0, cfg_q.limit};
            guard_pkg::GUARD_REG_MODE:  cfg_rdata = {30'h0, cfg_q.block_reads, cfg_q.enable};
            default:                    cfg_rdata = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/data_access_top.sv
`timescale 1ns/1ps
`default_nettype none

module data_access_top (
    input  logic                    clk,
    input  logic                    reset,
    input  mem_bus_pkg::data_req_t  dreq,
    output logic                    dreq_ready,
    output mem_bus_pkg::data_resp_t dresp,
    input  logic                    cfg_wen,
    input  logic [1:0]              cfg_addr,
    input  logic [31:0]             cfg_wdata,
    output logic [31:0]             cfg_rdata
);

    mem_bus_pkg::mem_req_t  memreq;
    logic                   memreq_ready;
    mem_bus_pkg::mem_resp_t memresp;
    guard_pkg::guard_cfg_t  guard_cfg;

    misaligned_access_ctrl i_misaligned_access_ctrl (
        .clk          (clk),
        .reset        (reset),
        .dreq         (dreq),
        .dreq_ready   (dreq_ready),
        .dresp        (dresp),
        .memreq       (memreq),
        .memreq_ready (memreq_ready),
        .memresp      (memresp)
    );

    word_mem i_word_mem (
        .clk          (clk),
        .reset        (reset),
        .memreq       (memreq),
        .memreq_ready (memreq_ready),
        .memresp      (memresp),
        .guard_cfg    (guard_cfg)
    );

    guard_regs i_guard_regs (
        .clk       (clk),
        .reset     (reset),
        .cfg_wen   (cfg_wen),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .guard_cfg (guard_cfg)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0; // released after the tenth rising edge
    end

endmodule

`default_nettype wire

//--- testbench/data_access_tb.sv
`timescale 1ns/1ps
`default_nettype none

module data_access_tb;

    localparam int PREFILL_WORDS = 32;
    localparam int NUM_REQUESTS  = 13 + 48 + 36 + 48 + 27 + 40; // per test, cfg accesses too
    localparam int CYCLE_LIMIT   = NUM_REQUESTS * 12 + 200;

    logic                    clk;
    logic                    reset;
    mem_bus_pkg::data_req_t  dreq;
    logic                    dreq_ready;
    mem_bus_pkg::data_resp_t dresp;
    logic                    cfg_wen;
    logic [1:0]              cfg_addr;
    logic [31:0]             cfg_wdata;
    logic [31:0]             cfg_rdata;

    logic [7:0]            shadow [1024]; // byte image of the word memory
    guard_pkg::guard_cfg_t model_cfg;     // what the guard registers should hold
    logic                  exp_load;
    logic                  exp_error;
    mem_bus_pkg::fault_t   exp_errty;
    logic [31:0]           exp_rdata;
    logic [31:0]           exp_mask;
    int                    error_count   = 0;
    int                    test_errors   = 0;
    int                    test_count    = 0;
    int                    request_count = 0;
    int                    cycle_count   = 0;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .reset(reset));

    data_access_top i_data_access_top (
        .clk        (clk),
        .reset      (reset),
        .dreq       (dreq),
        .dreq_ready (dreq_ready),
        .dresp      (dresp),
        .cfg_wen    (cfg_wen),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    a_resp_error: assert property (@(posedge clk) disable iff (reset)
        dresp.valid |-> dresp.error == exp_error)
        else begin
            error_count++;
            $display("** Error at %0t: dresp.error expected %0b, got %0b",
                     $time, exp_error, dresp.error);
        end

    a_resp_errty: assert property (@(posedge clk) disable iff (reset)
        dresp.valid && exp_error |-> dresp.errty == exp_errty)
        else begin
            error_count++;
            $display("** Error at %0t: dresp.errty expected %0d, got %0d",
                     $time, exp_errty, dresp.errty);
        end

    a_resp_rdata: assert property (@(posedge clk) disable iff (reset)
        dresp.valid && exp_load && !exp_error |->
            (dresp.rdata & exp_mask) == (exp_rdata & exp_mask))
        else begin
            error_count++;
            $display("** Error at %0t: dresp.rdata expected %h, got %h",
                     $time, exp_rdata & exp_mask, dresp.rdata & exp_mask);
        end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic mem_bus_pkg::access_size_t size_from_index(input int k);
        return (k == 0) ? mem_bus_pkg::SIZE_B : (k == 1) ? mem_bus_pkg::SIZE_H
                                                         : mem_bus_pkg::SIZE_W;
    endfunction

    // upper bits random and ignored by the memory
    function automatic logic [31:0] word_addr(input logic [7:0] w, input logic [1:0] off);
        logic [31:0] r;
        r = $urandom();
        return {r[31:10], w, off};
    endfunction

    function automatic logic [31:0] rand_addr(input int lo, input int count,
                                              input logic [1:0] off);
        return word_addr(8'(lo + int'($urandom() % count)), off);
    endfunction

    function automatic logic guard_hit(input logic [7:0] w, input logic is_write);
        return model_cfg.enable && w >= model_cfg.base && w <= model_cfg.limit &&
               (is_write || model_cfg.block_reads);
    endfunction

    function automatic logic [31:0] cfg_expected(input logic [1:0] a);
        case (a)
            guard_pkg::GUARD_REG_BASE:  return {24'h0, model_cfg.base};
            guard_pkg::GUARD_REG_LIMIT: return {24'h0, model_cfg.limit};
            guard_pkg::GUARD_REG_MODE:  return {30'h0, model_cfg.block_reads, model_cfg.enable};
            default:                    return 32'h0;
        endcase
    endfunction

    // one request on the byte image with reads before writes in word order
    task automatic predict(input logic wen, input mem_bus_pkg::access_size_t size,
                           input logic [31:0] addr, input logic [31:0] wdata);
        int         nbytes;
        int         p;
        logic [7:0] w0;
        logic [7:0] w1;
        logic       split;
        logic [9:0] bidx;
        nbytes    = (size == mem_bus_pkg::SIZE_B) ? 1 : (size == mem_bus_pkg::SIZE_H) ? 2 : 4;
        w0        = addr[9:2];
        w1        = w0 + 8'd1;
        split     = (size == mem_bus_pkg::SIZE_W && addr[1:0] != 2'd0) ||
                    (size == mem_bus_pkg::SIZE_H && addr[1:0] == 2'd3);
        exp_load  = !wen;
        exp_error = 1'b0;
        exp_errty = mem_bus_pkg::FE_LOAD_ACCESS;
        exp_rdata = 32'h0;
        exp_mask  = (nbytes == 1) ? 32'h0000_00ff : (nbytes == 2) ? 32'h0000_ffff : 32'hffff_ffff;
        if (!(wen && nbytes == 4 && addr[1:0] == 2'd0) &&
            (guard_hit(w0, 1'b0) || (split && guard_hit(w1, 1'b0)))) begin
            exp_error = 1'b1; // load or read step of a read-modify-write
        end else if (!wen) begin
            for (int i = 0; i < 4; i++) begin
                bidx = addr[9:0] + 10'(i);
                exp_rdata[i*8 +: 8] = shadow[bidx];
            end
        end else if (guard_hit(w0, 1'b1)) begin
            exp_error = 1'b1;
            exp_errty = mem_bus_pkg::FE_STORE_ACCESS;
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                p = int'(addr[1:0]) + i;
                if (p < 4) shadow[{w0, 2'(p)}] = wdata[i*8 +: 8];
            end
            if (split && guard_hit(w1, 1'b1)) begin
                exp_error = 1'b1; // first word keeps its write
                exp_errty = mem_bus_pkg::FE_STORE_ACCESS;
            end else begin
                for (int i = 0; i < nbytes; i++) begin
                    p = int'(addr[1:0]) + i;
                    if (p >= 4) shadow[{w1, 2'(p)}] = wdata[i*8 +: 8];
                end
            end
        end
    endtask

    // called on a falling edge, returns on a falling edge after the response
    task automatic issue(input logic wen, input mem_bus_pkg::access_size_t size,
                         input logic [31:0] addr, input logic [31:0] wdata);
        while (!dreq_ready) @(negedge clk);
        predict(wen, size, addr, wdata);
        dreq.valid = 1'b1;
        dreq.wen   = wen;
        dreq.size  = size;
        dreq.addr  = addr;
        dreq.wdata = wdata;
        @(negedge clk);
        dreq.valid = 1'b0;
        while (!dresp.valid) @(negedge clk);
        @(negedge clk); // response checked at the rising edge in between
        request_count++;
    endtask

    task automatic load_neighbors(input logic [31:0] addr);
        issue(1'b0, mem_bus_pkg::SIZE_W, {addr[31:2], 2'b00}, 32'h0);
        issue(1'b0, mem_bus_pkg::SIZE_W, {addr[31:2], 2'b00} + 32'd4, 32'h0);
    endtask

    task automatic write_cfg(input logic [1:0] a, input logic [31:0] d);
        cfg_wen   = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge clk);
        cfg_wen = 1'b0;
        case (a)
            guard_pkg::GUARD_REG_BASE:  model_cfg.base  = d[7:0];
            guard_pkg::GUARD_REG_LIMIT: model_cfg.limit = d[7:0];
            guard_pkg::GUARD_REG_MODE: begin
                model_cfg.enable      = d[0];
                model_cfg.block_reads = d[1];
            end
            default: ;
        endcase
    endtask

    task automatic check_cfg(input logic [1:0] a);
        logic [31:0] expected;
        expected = cfg_expected(a);
        cfg_addr = a;
        #1;
        a_cfg_rdata: assert (cfg_rdata == expected) else begin
            error_count++;
            $display("** Error at %0t: cfg_rdata (offset %0d) expected %h, got %h",
                     $time, a, expected, cfg_rdata);
        end
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %s, %0d errors", test_count, name,
                 (error_count == test_errors) ? "ok" : "FAILED", error_count - test_errors);
        test_errors = error_count;
    endtask

    initial begin
        logic [31:0] addr;
        dreq      = '0;
        cfg_wen   = 1'b0;
        cfg_addr  = 2'd0;
        cfg_wdata = 32'h0;
        model_cfg = '0;
        void'($urandom(86));
        @(negedge clk);
        while (reset) @(negedge clk);

        a_ready_after_reset: assert (dreq_ready) else begin
            error_count++;
            $display("** Error at %0t: dreq_ready expected 1, got %0b", $time, dreq_ready);
        end
        for (int a = 0; a < 4; a++) check_cfg(2'(a));
        write_cfg(guard_pkg::GUARD_REG_BASE, 32'hffff_ff12);
        write_cfg(guard_pkg::GUARD_REG_LIMIT, 32'habcd_ef34);
        write_cfg(guard_pkg::GUARD_REG_MODE, 32'hffff_ffff);
        write_cfg(2'd3, 32'hffff_ffff); // no register here
        for (int a = 0; a < 4; a++) check_cfg(2'(a));
        write_cfg(guard_pkg::GUARD_REG_MODE, 32'h0);
        end_test("guard registers after reset and read back");

        for (int w = 0; w < PREFILL_WORDS; w++) begin
            issue(1'b1, mem_bus_pkg::SIZE_W, word_addr(8'(w), 2'd0), $urandom());
        end
        for (int k = 0; k < 8; k++) begin
            addr = rand_addr(0, PREFILL_WORDS, 2'd0);
            issue(1'b1, mem_bus_pkg::SIZE_W, addr, $urandom());
            issue(1'b0, mem_bus_pkg::SIZE_W, addr, 32'h0);
        end
        end_test("aligned word store and load");

        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                for (int r = 0; r < 3; r++) begin
                    issue(1'b0, size_from_index(s), rand_addr(0, 30, 2'(off)), 32'h0);
                end
            end
        end
        end_test("loads at every offset");

        for (int s = 0; s < 2; s++) begin
            for (int off = 0; off < 4; off++) begin
                for (int r = 0; r < 2; r++) begin
                    addr = rand_addr(0, 30, 2'(off));
                    issue(1'b1, size_from_index(s), addr, $urandom());
                    load_neighbors(addr);
                end
            end
        end
        end_test("byte and half stores");

        for (int off = 1; off < 4; off++) begin
            for (int r = 0; r < 3; r++) begin
                addr = rand_addr(0, 30, 2'(off));
                issue(1'b1, mem_bus_pkg::SIZE_W, addr, $urandom());
                load_neighbors(addr);
            end
        end
        end_test("misaligned word stores");

        write_cfg(guard_pkg::GUARD_REG_BASE, 32'd20);
        write_cfg(guard_pkg::GUARD_REG_LIMIT, 32'd23);
        write_cfg(guard_pkg::GUARD_REG_MODE, 32'h1);
        issue(1'b1, mem_bus_pkg::SIZE_W, word_addr(8'd21, 2'd0), $urandom());
        issue(1'b0, mem_bus_pkg::SIZE_W, word_addr(8'd22, 2'd0), 32'h0);
        write_cfg(guard_pkg::GUARD_REG_MODE, 32'h3);
        issue(1'b0, mem_bus_pkg::SIZE_W, word_addr(8'd21, 2'd0), 32'h0);
        issue(1'b1, mem_bus_pkg::SIZE_H, word_addr(8'd22, 2'd1), $urandom());
        write_cfg(guard_pkg::GUARD_REG_MODE, 32'h1);
        issue(1'b1, mem_bus_pkg::SIZE_W, word_addr(8'd19, 2'd2), $urandom()); // second word guarded
        for (int k = 0; k < 16; k++) begin
            issue(1'($urandom() % 2), size_from_index(int'($urandom() % 3)),
                  rand_addr(16, 12, 2'($urandom() % 4)), $urandom());
        end
        write_cfg(guard_pkg::GUARD_REG_MODE, 32'h0);
        for (int w = 16; w < 29; w++) begin
            issue(1'b0, mem_bus_pkg::SIZE_W, word_addr(8'(w), 2'd0), 32'h0);
        end
        end_test("guard window faults");

        $display("summary: %0d tests, %0d requests, %0d errors",
                 test_count, request_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
rtl/mem_bus_pkg.sv
rtl/guard_pkg.sv
rtl/misaligned_access_ctrl.sv
rtl/word_mem.sv
rtl/guard_regs.sv
rtl/data_access_top.sv
testbench/tb_clock_gen.sv
testbench/data_access_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= data_access_tb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All checks passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
